/* Makefile */
VERILATOR ?= verilator
FLAGS     := --binary --timing --assert -Wno-fatal
TOP       := tb_wts
FLIST     := flist.f
OBJ       := obj_dir
LOG       := sim.log

.PHONY: all run lint clean

all: run

$(OBJ)/V$(TOP): $(FLIST) *.sv *.svh
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ) -f $(FLIST)

run: $(OBJ)/V$(TOP)
	./$(OBJ)/V$(TOP) +verilator+error+limit+100 | tee $(LOG)
	@if grep -q "Verification failed" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "Verification passed" $(LOG) || { echo "Simulation ended without a result"; exit 1; }

lint:
	$(VERILATOR) --lint-only -Wall --timing --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ) $(LOG)

/* flist.f */
+incdir+.
wts_pkg.sv
wts_tone_generator.sv
wts_ram_arbiter.sv
wts_wave_ram.sv
wts_channel_volume.sv
wts_mixer.sv
wts_sound_top.sv
wts_checker.sv
tb_wts.sv

/* tb_wts.sv */
// Drives the sound top through Wishbone and channel registers and expects 2048 plus frame sums
`include "wts_cfg.svh"

module tb_wts;
	import wts_pkg::*;

	localparam int FRAME = 8;
	// Test 4 writes 160 bytes at up to ten cycles each and test 5 runs 40 frames
	localparam int CYCLE_LIMIT = 20000;

	logic						clk;
	logic						nreset;
	ch_reg_t					ch_regs [`WTS_CHANNELS];
	wb_req_t					wb_req;
	wb_rsp_t					wb_rsp;
	logic [`WTS_OUT_BITS-1:0]	left_out;
	logic [`WTS_OUT_BITS-1:0]	right_out;

	logic [31:0]	lfsr_state = 32'hcd95_0339;
	logic [7:0]		ram_model [256];
	int				checks = 0;
	int				errors = 0;
	int				tests = 0;
	int				cycle_count = 0;

	wts_sound_top uut (
		.clk		( clk		),
		.nreset		( nreset	),
		.ch_regs	( ch_regs	),
		.wb_req		( wb_req	),
		.wb_rsp		( wb_rsp	),
		.left_out	( left_out	),
		.right_out	( right_out	)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	always @( posedge clk ) begin
		cycle_count <= cycle_count + 1;
		if( cycle_count >= CYCLE_LIMIT ) begin
			$display("Run stopped after %0d cycles without finishing the tests", cycle_count);
			$display("Verification failed");
			$finish;
		end
	end

	// ----------------------------------------------------------------------
	// Helpers
	// ----------------------------------------------------------------------
	// Fibonacci LFSR with taps 32, 22, 2 and 1, one step per bit
	function automatic logic [31:0] random_bits( input int n );
		logic [31:0]	value;
		logic			fb;
		value = '0;
		for( int i = 0; i < n; i++ ) begin
			fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
			lfsr_state = { lfsr_state[30:0], fb };
			value = { value[30:0], fb };
		end
		return value;
	endfunction

	// Signed sample times volume over 16, rounded toward minus infinity
	function automatic int scaled_sample( input logic [7:0] sample, input logic [3:0] volume );
		int product;
		product = int'( $signed( sample ) ) * int'( volume );
		return product >>> 4;
	endfunction

	task automatic check_equal( input string name, input int got, input int expected );
		checks++;
		assert( got == expected ) else begin
			$display("[FAIL] %0t %s got %0d expected %0d", $time, name, got, expected);
			errors++;
		end
	endtask

	task automatic write_byte( input logic [7:0] adr, input logic [7:0] data );
		wb_req_t req;
		req = '{ cyc: 1'b1, stb: 1'b1, we: 1'b1, adr: adr, dat_w: data };
		@( posedge clk );
		wb_req <= req;
		do begin
			@( negedge clk );
		end while( !wb_rsp.ack );
		@( posedge clk );
		wb_req <= '0;
		ram_model[adr] = data;
	endtask

	task automatic read_byte( input logic [7:0] adr, output logic [7:0] data );
		wb_req_t req;
		req = '{ cyc: 1'b1, stb: 1'b1, we: 1'b0, adr: adr, dat_w: 8'h00 };
		@( posedge clk );
		wb_req <= req;
		do begin
			@( negedge clk );
		end while( !wb_rsp.ack );
		data = wb_rsp.dat_r;
		@( posedge clk );
		wb_req <= '0;
	endtask

	task automatic set_channel( input int ch, input ch_reg_t settings );
		@( posedge clk );
		ch_regs[ch] <= settings;
	endtask

	// Settings reach every sample of a frame within two frames
	task automatic check_outputs( input int exp_left, input int exp_right );
		repeat( 2 * FRAME ) @( posedge clk );
		repeat( FRAME ) begin
			@( negedge clk );
			check_equal("left_out", int'( left_out ), exp_left);
			check_equal("right_out", int'( right_out ), exp_right);
		end
	endtask

	task automatic finish_test( input string name, input int errors_before );
		tests++;
		$display("test %0d %-26s %s", tests, name, ( errors == errors_before ) ? "ok" : "errors");
	endtask

	// ----------------------------------------------------------------------
	// Test sequence
	// ----------------------------------------------------------------------
	initial begin
		logic [7:0]	addrs [16];
		logic [7:0]	data;
		logic [7:0]	got;
		logic [7:0]	ch_value [`WTS_CHANNELS];
		ch_reg_t	ch_set [`WTS_CHANNELS];
		int			ramp_scaled [32];
		logic [31:0]	seen;
		int			sum_left;
		int			sum_right;
		int			index;
		int			mark;

		nreset = 1'b0;
		wb_req = '0;
		for( int c = 0; c < `WTS_CHANNELS; c++ ) begin
			ch_regs[c] = '0;
		end
		repeat( 2 ) @( posedge clk );
		nreset <= 1'b1;

		// Silence after reset
		mark = errors;
		repeat( 4 * FRAME ) begin
			@( negedge clk );
			check_equal("left_out", int'( left_out ), 2048);
			check_equal("right_out", int'( right_out ), 2048);
			check_equal("wb_rsp.ack", int'( wb_rsp.ack ), 0);
		end
		finish_test("reset silence", mark);

		mark = errors;
		for( int i = 0; i < 16; i++ ) begin
			addrs[i] = 8'( random_bits( 8 ) );
			data = 8'( random_bits( 8 ) );
			write_byte(addrs[i], data);
			read_byte(addrs[i], got);
			check_equal("wb_rsp.dat_r", int'( got ), int'( data ));
		end
		// Reverse order so a stale byte from a neighbour shows up
		for( int i = 15; i >= 0; i-- ) begin
			read_byte(addrs[i], got);
			check_equal("wb_rsp.dat_r", int'( got ), int'( ram_model[addrs[i]] ));
		end
		finish_test("wishbone write and read", mark);

		mark = errors;
		data = 8'( random_bits( 8 ) );
		ch_set[0] = '{ volume: 4'( random_bits( 4 ) ) | 4'd1, enable: 2'b10, frequency_count: 12'd0 };
		for( int i = 0; i < 32; i++ ) begin
			write_byte({ 3'd0, 5'( i ) }, data);
		end
		set_channel(0, ch_set[0]);
		check_outputs(2048 + scaled_sample( data, ch_set[0].volume ), 2048);
		finish_test("channel A constant left", mark);

		mark = errors;
		sum_left = 0;
		sum_right = 0;
		for( int c = 0; c < `WTS_CHANNELS; c++ ) begin
			ch_value[c] = 8'( random_bits( 8 ) );
			ch_set[c].volume = 4'( random_bits( 4 ) );
			ch_set[c].enable = 2'( random_bits( 2 ) );
			ch_set[c].frequency_count = 12'( random_bits( 3 ) );
			for( int i = 0; i < 32; i++ ) begin
				write_byte({ 3'( c ), 5'( i ) }, ch_value[c]);
			end
			if( ch_set[c].enable[1] ) begin
				sum_left += scaled_sample( ch_value[c], ch_set[c].volume );
			end
			if( ch_set[c].enable[0] ) begin
				sum_right += scaled_sample( ch_value[c], ch_set[c].volume );
			end
		end
		for( int c = 0; c < `WTS_CHANNELS; c++ ) begin
			set_channel(c, ch_set[c]);
		end
		check_outputs(2048 + sum_left, 2048 + sum_right);
		finish_test("five channel mix", mark);

		mark = errors;
		seen = '0;
		for( int c = 0; c < `WTS_CHANNELS; c++ ) begin
			set_channel(c, '0);
		end
		for( int i = 0; i < 32; i++ ) begin
			data = 8'( 7 * i - 100 );
			ramp_scaled[i] = scaled_sample( data, 4'd15 );
			write_byte({ 3'd1, 5'( i ) }, data);
		end
		set_channel(1, '{ volume: 4'd15, enable: 2'b11, frequency_count: 12'd0 });
		repeat( 2 * FRAME ) @( posedge clk );
		for( int f = 0; f < 40; f++ ) begin
			repeat( FRAME ) @( negedge clk );
			index = -1;
			for( int i = 0; i < 32; i++ ) begin
				if( int'( left_out ) == 2048 + ramp_scaled[i] ) begin
					index = i;
				end
			end
			checks++;
			assert( index >= 0 ) else begin
				$display("[FAIL] %0t left_out got %0d expected one of the ramp values",
					$time, left_out);
				errors++;
			end
			if( index >= 0 ) begin
				check_equal("right_out", int'( right_out ), 2048 + ramp_scaled[index]);
				seen[index] = 1'b1;
			end
		end
		checks++;
		assert( $countones( seen ) > 1 ) else begin
			$display("Ramp on channel B gave only %0d distinct output value", $countones( seen ));
			errors++;
		end
		finish_test("channel B ramp", mark);

		$display("tests %0d, checks %0d, errors %0d, checker errors %0d",
			tests, checks, errors, uut.u_checker.fail_count);
		if( errors == 0 && uut.u_checker.fail_count == 0 ) begin
			$display("Verification passed");
		end
		else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

/* wts_cfg.svh */
// Sizes are fixed by the eight-slot schedule and changing them needs matching RTL changes
`ifndef WTS_CFG_SVH
`define WTS_CFG_SVH

// ---------------------------------------------------------------------
// Channel and sample sizes
// ---------------------------------------------------------------------
// Five tone channels A to E share one frame of eight slots
`define WTS_CHANNELS		5
`define WTS_SAMPLE_BITS		8

// Each waveform has 32 samples
`define WTS_WAVE_BITS		5

// Top three bits pick the channel and the low five pick the sample
`define WTS_RAM_ADDR_BITS	8

// ---------------------------------------------------------------------
// Register and output sizes
// ---------------------------------------------------------------------
`define WTS_VOLUME_BITS		4
`define WTS_FREQ_BITS		12
`define WTS_OUT_BITS		12

`endif

/* wts_channel_volume.sv */
// Samples are two's complement and the volume scale rounds toward minus infinity
`include "wts_cfg.svh"

module wts_channel_volume (
	input									clk,
	input									nreset,
	input	[`WTS_SAMPLE_BITS-1:0]			ram_q,
	input	wts_pkg::sample_tag_t			sample_tag,
	input	wts_pkg::ch_reg_t				ch_regs [`WTS_CHANNELS],
	output	wts_pkg::pan_sample_t			pan_sample
);
	import wts_pkg::*;

	localparam int PRODUCT_BITS = `WTS_SAMPLE_BITS + `WTS_VOLUME_BITS + 1;

	ch_reg_t							w_reg;
	logic signed [PRODUCT_BITS-1:0]		w_product;
	logic signed [`WTS_SAMPLE_BITS-1:0]	w_scaled;
	pan_sample_t						ff_pan;

	// Settings of the channel whose sample is on ram_q
	always_comb begin
		w_reg = '0;
		for( int i = 0; i < `WTS_CHANNELS; i++ ) begin
			if( sample_tag.ch == slot_e'( i ) ) begin
				w_reg = ch_regs[i];
			end
		end
	end

	// Volume is unsigned so it gets a zero sign bit before the multiply
	assign w_product	= $signed( ram_q ) * $signed( { 1'b0, w_reg.volume } );
	assign w_scaled		= w_product[`WTS_SAMPLE_BITS+`WTS_VOLUME_BITS-1:`WTS_VOLUME_BITS];

	always_ff @( posedge clk ) begin
		if( !nreset ) begin
			ff_pan <= '0;
		end
		else begin
			ff_pan.valid	<= sample_tag.valid;
			ff_pan.first	<= sample_tag.valid && ( sample_tag.ch == SLOT_A );
			ff_pan.last		<= sample_tag.valid && ( sample_tag.ch == SLOT_E );
			ff_pan.left		<= w_reg.enable[1] ? w_scaled : '0;
			ff_pan.right	<= w_reg.enable[0] ? w_scaled : '0;
		end
	end

	assign pan_sample = ff_pan;

endmodule

/* wts_checker.sv */
// Bound to the sound top and reads its internal slot to find frame boundaries
`include "wts_cfg.svh"

module wts_checker (
	input								clk,
	input								nreset,
	input	wts_pkg::slot_e				slot,
	input	wts_pkg::wb_req_t			wb_req,
	input	wts_pkg::wb_rsp_t			wb_rsp,
	input	[`WTS_OUT_BITS-1:0]			left_out,
	input	[`WTS_OUT_BITS-1:0]			right_out
);
	import wts_pkg::*;

	int		fail_count = 0;
	int		stb_wait;

	// Cycles that stb has waited without an ack
	always_ff @( posedge clk ) begin
		if( !nreset || !wb_req.stb || wb_rsp.ack ) begin
			stb_wait <= 0;
		end
		else begin
			stb_wait <= stb_wait + 1;
		end
	end

	// ----------------------------------------------------------------------
	// Wishbone handshake
	// ----------------------------------------------------------------------
	ack_single: assert property ( @( posedge clk ) disable iff ( !nreset )
		wb_rsp.ack |=> !wb_rsp.ack )
		else begin
			$error("ack stayed high for more than one cycle");
			fail_count = fail_count + 1;
		end

	ack_with_stb: assert property ( @( posedge clk ) disable iff ( !nreset )
		wb_rsp.ack |-> ( wb_req.cyc && wb_req.stb ) )
		else begin
			$error("ack high without cyc and stb");
			fail_count = fail_count + 1;
		end

	// A CPU slot comes round every eight cycles
	ack_latency: assert property ( @( posedge clk ) disable iff ( !nreset )
		stb_wait <= 9 )
		else begin
			$error("no ack within 9 cycles of stb");
			fail_count = fail_count + 1;
		end

	// ----------------------------------------------------------------------
	// Outputs
	// ----------------------------------------------------------------------
	// New frame sums appear during the last slot of a frame
	frame_update: assert property ( @( posedge clk ) disable iff ( !nreset )
		( $changed( left_out ) || $changed( right_out ) ) |-> ( slot == SLOT_IDLE7 ) )
		else begin
			$error("output changed away from a frame boundary");
			fail_count = fail_count + 1;
		end

	known_after_reset: assert property ( @( posedge clk ) disable iff ( !nreset )
		!$isunknown( { left_out, right_out, wb_rsp.ack, slot } ) )
		else begin
			$error("unknown value on an output or the slot");
			fail_count = fail_count + 1;
		end

endmodule

bind wts_sound_top wts_checker u_checker (
	.clk		( clk		),
	.nreset		( nreset	),
	.slot		( slot		),
	.wb_req		( wb_req	),
	.wb_rsp		( wb_rsp	),
	.left_out	( left_out	),
	.right_out	( right_out	)
);

/* wts_mixer.sv */
// Frame sums wrap silently beyond the 12-bit signed range and outputs change once per frame
`include "wts_cfg.svh"

module wts_mixer (
	input									clk,
	input									nreset,
	input	wts_pkg::pan_sample_t			pan_sample,
	output	logic [`WTS_OUT_BITS-1:0]		left_out,
	output	logic [`WTS_OUT_BITS-1:0]		right_out
);

	logic signed [`WTS_OUT_BITS-1:0]	ff_left_acc;
	logic signed [`WTS_OUT_BITS-1:0]	ff_right_acc;
	logic signed [`WTS_OUT_BITS-1:0]	w_left_ext;
	logic signed [`WTS_OUT_BITS-1:0]	w_right_ext;
	logic signed [`WTS_OUT_BITS-1:0]	w_left_sum;
	logic signed [`WTS_OUT_BITS-1:0]	w_right_sum;

	// Sign extension of the scaled samples
	assign w_left_ext	= pan_sample.left;
	assign w_right_ext	= pan_sample.right;

	// A first sample starts a new frame sum
	assign w_left_sum	= pan_sample.first ? w_left_ext  : ff_left_acc  + w_left_ext;
	assign w_right_sum	= pan_sample.first ? w_right_ext : ff_right_acc + w_right_ext;

	always_ff @( posedge clk ) begin
		if( !nreset ) begin
			ff_left_acc		<= '0;
			ff_right_acc	<= '0;
			left_out		<= { 1'b1, { ( `WTS_OUT_BITS - 1 ) { 1'b0 } } };
			right_out		<= { 1'b1, { ( `WTS_OUT_BITS - 1 ) { 1'b0 } } };
		end
		else if( pan_sample.valid ) begin
			ff_left_acc		<= w_left_sum;
			ff_right_acc	<= w_right_sum;
			// Inverting the top bit turns the signed sum into offset binary
			if( pan_sample.last ) begin
				left_out	<= { ~w_left_sum[`WTS_OUT_BITS-1],  w_left_sum[`WTS_OUT_BITS-2:0]  };
				right_out	<= { ~w_right_sum[`WTS_OUT_BITS-1], w_right_sum[`WTS_OUT_BITS-2:0] };
			end
		end
	end

endmodule

/* wts_pkg.sv */
// Shared types assume the sizes in the config header and a fixed five-channel slot order
`include "wts_cfg.svh"

package wts_pkg;

	// Slot order inside one eight-cycle frame
	typedef enum logic [2:0] {
		SLOT_A		= 3'd0,
		SLOT_B		= 3'd1,
		SLOT_C		= 3'd2,
		SLOT_D		= 3'd3,
		SLOT_E		= 3'd4,
		SLOT_CPU	= 3'd5,
		SLOT_IDLE6	= 3'd6,
		SLOT_IDLE7	= 3'd7
	} slot_e;

	// Enable bit 1 feeds the left side and bit 0 the right side
	typedef struct packed {
		logic [`WTS_VOLUME_BITS-1:0]	volume;
		logic [1:0]						enable;
		logic [`WTS_FREQ_BITS-1:0]		frequency_count;
	} ch_reg_t;

	typedef struct packed {
		logic							cyc;
		logic							stb;
		logic							we;
		logic [`WTS_RAM_ADDR_BITS-1:0]	adr;
		logic [`WTS_SAMPLE_BITS-1:0]	dat_w;
	} wb_req_t;

	typedef struct packed {
		logic							ack;
		logic [`WTS_SAMPLE_BITS-1:0]	dat_r;
	} wb_rsp_t;

	typedef struct packed {
		logic							we;
		logic [`WTS_RAM_ADDR_BITS-1:0]	addr;
		logic [`WTS_SAMPLE_BITS-1:0]	data;
	} ram_req_t;

	typedef struct packed {
		logic	valid;
		slot_e	ch;
	} sample_tag_t;

	typedef struct packed {
		logic							valid;
		logic							first;
		logic							last;
		logic signed [`WTS_SAMPLE_BITS-1:0]	left;
		logic signed [`WTS_SAMPLE_BITS-1:0]	right;
	} pan_sample_t;

endpackage

/* wts_ram_arbiter.sv */
// A Wishbone access waits for SLOT_CPU and the master must hold its request until ack
`include "wts_cfg.svh"

module wts_ram_arbiter (
	input									clk,
	input									nreset,
	input	wts_pkg::slot_e					slot,
	input	[`WTS_WAVE_BITS-1:0]			wave_address,
	input	wts_pkg::wb_req_t				wb_req,
	output	wts_pkg::wb_rsp_t				wb_rsp,
	output	wts_pkg::ram_req_t				ram_req,
	input	[`WTS_SAMPLE_BITS-1:0]			ram_q,
	output	wts_pkg::sample_tag_t			sample_tag
);
	import wts_pkg::*;

	logic			w_tone_slot;
	logic			w_cpu_access;
	logic			ff_ack;
	sample_tag_t	ff_tag;

	assign w_tone_slot	= ( slot <= SLOT_E );
	assign w_cpu_access	= ( slot == SLOT_CPU ) && wb_req.cyc && wb_req.stb;

	// ---------------------------------------------------------------------
	// RAM port sharing
	// ---------------------------------------------------------------------
	// Tone slots read their own channel page and every other slot uses the bus address
	always_comb begin
		ram_req.we		= w_cpu_access && wb_req.we;
		ram_req.addr	= w_tone_slot ? { slot, wave_address } : wb_req.adr;
		ram_req.data	= wb_req.dat_w;
	end

	// ---------------------------------------------------------------------
	// Read tag and bus acknowledge
	// ---------------------------------------------------------------------
	always_ff @( posedge clk ) begin
		if( !nreset ) begin
			ff_ack			<= 1'b0;
			ff_tag.valid	<= 1'b0;
			ff_tag.ch		<= SLOT_A;
		end
		else begin
			// One pulse per access since the next CPU slot is a frame away
			ff_ack			<= w_cpu_access;
			ff_tag.valid	<= w_tone_slot;
			ff_tag.ch		<= slot;
		end
	end

	// Read data lines up with ack because the RAM read is registered
	assign wb_rsp.ack	= ff_ack;
	assign wb_rsp.dat_r	= ram_q;
	assign sample_tag	= ff_tag;

endmodule

/* wts_sound_top.sv */
// Channel registers are sampled live every frame and CPU access goes through Wishbone classic
`include "wts_cfg.svh"

module wts_sound_top (
	input									clk,
	input									nreset,
	input	wts_pkg::ch_reg_t				ch_regs [`WTS_CHANNELS],
	input	wts_pkg::wb_req_t				wb_req,
	output	wts_pkg::wb_rsp_t				wb_rsp,
	output	[`WTS_OUT_BITS-1:0]				left_out,
	output	[`WTS_OUT_BITS-1:0]				right_out
);
	import wts_pkg::*;

	slot_e							slot;
	logic [`WTS_WAVE_BITS-1:0]		wave_address;
	ram_req_t						ram_req;
	logic [`WTS_SAMPLE_BITS-1:0]	ram_q;
	sample_tag_t					sample_tag;
	pan_sample_t					pan_sample;

	// ---------------------------------------------------------------------
	// Slot schedule and RAM access
	// ---------------------------------------------------------------------
	wts_tone_generator u_tone_generator (
		.clk			( clk				),
		.nreset			( nreset			),
		.ch_regs		( ch_regs			),
		.slot			( slot				),
		.wave_address	( wave_address		)
	);

	wts_ram_arbiter u_ram_arbiter (
		.clk			( clk				),
		.nreset			( nreset			),
		.slot			( slot				),
		.wave_address	( wave_address		),
		.wb_req			( wb_req			),
		.wb_rsp			( wb_rsp			),
		.ram_req		( ram_req			),
		.ram_q			( ram_q				),
		.sample_tag		( sample_tag		)
	);

	wts_wave_ram u_wave_ram (
		.clk			( clk				),
		.ram_req		( ram_req			),
		.ram_q			( ram_q				)
	);

	// ---------------------------------------------------------------------
	// Sample path to the outputs
	// ---------------------------------------------------------------------
	wts_channel_volume u_channel_volume (
		.clk			( clk				),
		.nreset			( nreset			),
		.ram_q			( ram_q				),
		.sample_tag		( sample_tag		),
		.ch_regs		( ch_regs			),
		.pan_sample		( pan_sample		)
	);

	wts_mixer u_mixer (
		.clk			( clk				),
		.nreset			( nreset			),
		.pan_sample		( pan_sample		),
		.left_out		( left_out			),
		.right_out		( right_out			)
	);

endmodule

/* wts_tone_generator.sv */
// Phase counters reset to address zero and a channel only advances in its own slot once per frame
`include "wts_cfg.svh"

module wts_tone_generator (
	input									clk,
	input									nreset,
	input	wts_pkg::ch_reg_t				ch_regs [`WTS_CHANNELS],
	output	wts_pkg::slot_e					slot,
	output	logic [`WTS_WAVE_BITS-1:0]		wave_address
);
	import wts_pkg::*;

	slot_e							ff_slot;
	logic [`WTS_FREQ_BITS-1:0]		ff_count [`WTS_CHANNELS];
	logic [`WTS_WAVE_BITS-1:0]		ff_wave_address [`WTS_CHANNELS];

	// ---------------------------------------------------------------------
	// Frame slot counter
	// ---------------------------------------------------------------------
	always_ff @( posedge clk ) begin
		if( !nreset ) begin
			ff_slot <= SLOT_A;
		end
		else begin
			// Wraps from SLOT_IDLE7 back to SLOT_A
			ff_slot <= slot_e'( ff_slot + 3'd1 );
		end
	end

	// ---------------------------------------------------------------------
	// Per-channel phase counters
	// ---------------------------------------------------------------------
	always_ff @( posedge clk ) begin
		if( !nreset ) begin
			for( int i = 0; i < `WTS_CHANNELS; i++ ) begin
				ff_count[i]			<= '0;
				ff_wave_address[i]	<= '0;
			end
		end
		else begin
			for( int i = 0; i < `WTS_CHANNELS; i++ ) begin
				if( ff_slot == slot_e'( i ) ) begin
					// A count of N gives one step every N+1 frames
					if( ff_count[i] == '0 ) begin
						ff_count[i]			<= ch_regs[i].frequency_count;
						ff_wave_address[i]	<= ff_wave_address[i] + 1'b1;
					end
					else begin
						ff_count[i]			<= ff_count[i] - 1'b1;
					end
				end
			end
		end
	end

	// The owner of the current slot presents its address
	always_comb begin
		wave_address = '0;
		for( int i = 0; i < `WTS_CHANNELS; i++ ) begin
			if( ff_slot == slot_e'( i ) ) begin
				wave_address = ff_wave_address[i];
			end
		end
	end

	assign slot = ff_slot;

endmodule

/* wts_wave_ram.sv */
// Contents are undefined until written and a write returns the old byte on the read port
`include "wts_cfg.svh"

module wts_wave_ram (
	input									clk,
	input	wts_pkg::ram_req_t				ram_req,
	output	logic [`WTS_SAMPLE_BITS-1:0]	ram_q
);

	logic [`WTS_SAMPLE_BITS-1:0]	mem [2**`WTS_RAM_ADDR_BITS];

	// Single port with a registered read every cycle
	always_ff @( posedge clk ) begin
		if( ram_req.we ) begin
			mem[ram_req.addr] <= ram_req.data;
		end
		ram_q <= mem[ram_req.addr];
	end

endmodule
